/* files.f */
+incdir+verilog
verilog/lsu_pkg.sv
verilog/axi_if.sv
verilog/stage_reg.sv
verilog/lsu_align.sv
verilog/lsu_core.sv
verilog/axi_mem.sv
verilog/lsu_top.sv
sim/lsu_sva.sv
sim/lsu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the load/store stage testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f files.f --top-module lsu_tb \
    -o lsu_tb_sim > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/lsu_tb_sim > sim.log 2>&1 || echo "Simulator returned an error status" >> sim.log
cat sim.log

grep -qF "** FAIL **" sim.log && exit 1
grep -qF "** PASS **" sim.log && exit 0 || { echo "No result line in sim.log"; exit 1; }

/* sim/lsu_sva.sv */
module lsu_sva (
    input logic              clk,
    input logic              rst,
    input logic              arvalid,
    input logic              arready,
    input logic              awvalid,
    input logic              awready,
    input logic              wvalid,
    input logic              bready,
    input logic              rready,
    input logic              out_valid,
    input logic              out_ready,
    input lsu_pkg::lsu_rsp_t out_rsp
);
    // Address valids hold until accepted
    ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid) else $error("arvalid dropped before arready");
    aw_hold: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid) else $error("awvalid dropped before awready");

    // One transaction at a time
    no_overlap: assert property (@(posedge clk) disable iff (rst)
        !((arvalid || rready) && (awvalid || wvalid || bready)))
        else $error("read and write active together");

    rsp_stable: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_rsp))
        else $error("out_rsp changed while waiting for out_ready");

endmodule

/* sim/lsu_tb.sv */
`include "lsu_defines.svh"

module lsu_tb;
    import lsu_pkg::*;

    localparam int N_RAND  = 60;
    localparam int N_REQ   = 2 * `LSU_MEM_WORDS + 16 + 26 + 4 + 4 + N_RAND;
    localparam int TIMEOUT = N_REQ * 50 * 10 + 2000;

    logic     clk;
    logic     rst;
    logic     req_valid;
    logic     req_ready;
    lsu_req_t req;
    logic     rsp_valid;
    logic     rsp_ready;
    lsu_rsp_t rsp;
    logic [7:0] ref_mem [`LSU_MEM_WORDS*4];
    int       seed = 32'h15a5a13a;
    int       tag = 0;

    lsu_top lsu_top_i (.*);

    bind lsu_core lsu_sva u_sva (
        .clk(clk), .rst(rst),
        .arvalid(axi.arvalid), .arready(axi.arready),
        .awvalid(axi.awvalid), .awready(axi.awready),
        .wvalid(axi.wvalid), .bready(axi.bready), .rready(axi.rready),
        .out_valid(out_valid), .out_ready(out_ready), .out_rsp(out_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(TIMEOUT);
        $display("Watchdog expired, the simulation hung waiting for the DUT");
        $display("** FAIL **");
        $fatal(1, "timeout");
    end

    function automatic logic window_hit(input word_t a);
        return a >= `LSU_MEM_BASE && a < `LSU_MEM_BASE + `LSU_MEM_WORDS * 4;
    endfunction

    // Builds the expected record and updates the byte model for stores
    function automatic lsu_rsp_t model(input lsu_req_t r);
        lsu_rsp_t    e;
        int unsigned off;
        int          n;
        word_t       v;
        e = '{pc: r.pc, rd: r.rd, gpr_we: r.gpr_we, is_load: r.kind == KIND_LOAD,
              data: '0, fault: 1'b0};
        n = (r.size == SIZE_BYTE) ? 1 : (r.size == SIZE_HALF) ? 2 : 4;
        v = '0;
        if (r.kind == KIND_PASS) begin
            e.data = r.addr;
        end else if (!window_hit(r.addr)) begin
            e.fault = 1'b1;
        end else begin
            off = r.addr - `LSU_MEM_BASE;
            for (int i = 0; i < n; i++) begin
                if (r.kind == KIND_STORE) ref_mem[off+i] = r.wdata[8*i +: 8];
                else v[8*i +: 8] = ref_mem[off+i];
            end
            if (r.kind == KIND_LOAD && r.sext && n < 4 && v[8*n-1]) begin
                for (int i = n; i < 4; i++) v[8*i +: 8] = 8'hff;
            end
            if (r.kind == KIND_LOAD) e.data = v;
        end
        return e;
    endfunction

    function automatic lsu_req_t make_req(input lsu_kind_e k, input lsu_size_e s,
                                          input logic sx, input word_t a, input word_t d);
        lsu_req_t r;
        r = '{kind: k, size: s, sext: sx, rd: tag[4:0], gpr_we: k != KIND_STORE,
              pc: 32'h0000_1000 + 4 * tag, addr: a, wdata: d};
        tag++;
        return r;
    endfunction

    task automatic compare_rsp(input lsu_rsp_t got, input lsu_rsp_t exp, input string msg);
        if (got !== exp) begin
            $display("error %0t: %s record %h expected %h", $time, msg, got, exp);
            $display("** FAIL **");
            $fatal(1, "response mismatch");
        end
    endtask

    task automatic compare_word(input word_t got, input word_t exp, input string msg);
        if (got !== exp) begin
            $display("error %0t: %s data %h expected %h", $time, msg, got, exp);
            $display("** FAIL **");
            $fatal(1, "data mismatch");
        end
    endtask

    // Called and returns 1 unit after a rising edge
    task automatic send_req(input lsu_req_t r);
        req_valid = 1'b1;
        req = r;
        while (!req_ready) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    task automatic get_rsp(output lsu_rsp_t r, input logic random_ready);
        logic taken;
        taken = 1'b0;
        while (!taken) begin
            rsp_ready = random_ready ? $random(seed) & 1 : 1'b1;
            taken = rsp_valid && rsp_ready;
            r = rsp;
            @(posedge clk);
            #1;
        end
        rsp_ready = 1'b0;
    endtask

    task automatic run_one(input lsu_req_t r, input string msg);
        lsu_rsp_t exp;
        lsu_rsp_t got;
        exp = model(r);
        send_req(r);
        get_rsp(got, 1'b0);
        compare_word(got.data, exp.data, msg);
        compare_rsp(got, exp, msg);
    endtask

    task automatic fill_memory();
        word_t a;
        for (int i = 0; i < `LSU_MEM_WORDS; i++) begin
            a = `LSU_MEM_BASE + 4 * i;
            run_one(make_req(KIND_STORE, SIZE_WORD, 1'b0, a, a ^ {a[15:0], a[31:16]}), "fill");
        end
    endtask

    task automatic word_store_load();
        word_t a;
        for (int i = 0; i < 8; i++) begin
            a = `LSU_MEM_BASE + 4 * (i * 131 % `LSU_MEM_WORDS);
            run_one(make_req(KIND_STORE, SIZE_WORD, 1'b0, a, $random(seed)), "word store");
            run_one(make_req(KIND_LOAD, SIZE_WORD, 1'b0, a, '0), "word load");
        end
    endtask

    task automatic sub_word_lanes();
        word_t w;
        w = `LSU_MEM_BASE + 32'h100;
        for (int off = 0; off < 4; off++) begin
            run_one(make_req(KIND_STORE, SIZE_BYTE, 1'b0, w + off, $random(seed)), "sb");
            run_one(make_req(KIND_LOAD, SIZE_WORD, 1'b0, w, '0), "lanes after sb");
            run_one(make_req(KIND_LOAD, SIZE_BYTE, 1'b1, w + off, '0), "lb");
            run_one(make_req(KIND_LOAD, SIZE_BYTE, 1'b0, w + off, '0), "lbu");
        end
        for (int off = 0; off < 4; off += 2) begin
            run_one(make_req(KIND_STORE, SIZE_HALF, 1'b0, w + off, $random(seed)), "sh");
            run_one(make_req(KIND_LOAD, SIZE_WORD, 1'b0, w, '0), "lanes after sh");
            run_one(make_req(KIND_LOAD, SIZE_HALF, 1'b1, w + off, '0), "lh");
            run_one(make_req(KIND_LOAD, SIZE_HALF, 1'b0, w + off, '0), "lhu");
        end
        run_one(make_req(KIND_STORE, SIZE_HALF, 1'b0, w + 2, 32'h0000_8001), "sh neg");
        run_one(make_req(KIND_LOAD, SIZE_HALF, 1'b1, w + 2, '0), "lh neg");
    endtask

    task automatic pass_through();
        for (int i = 0; i < 4; i++) begin
            run_one(make_req(KIND_PASS, SIZE_WORD, 1'b0, $random(seed), '0), "pass");
        end
    endtask

    task automatic fault_access();
        word_t bad_hi;
        bad_hi = `LSU_MEM_BASE + `LSU_MEM_WORDS * 4;
        run_one(make_req(KIND_LOAD, SIZE_WORD, 1'b0, 32'h0000_1000, '0), "fault load low");
        run_one(make_req(KIND_LOAD, SIZE_BYTE, 1'b1, bad_hi, '0), "fault load high");
        run_one(make_req(KIND_STORE, SIZE_WORD, 1'b0, bad_hi, 32'hdead_beef), "fault store");
        run_one(make_req(KIND_STORE, SIZE_BYTE, 1'b0, 32'h7fff_fffc, 32'hff), "fault sb");
        for (int i = 0; i < `LSU_MEM_WORDS; i++) begin
            run_one(make_req(KIND_LOAD, SIZE_WORD, 1'b0, `LSU_MEM_BASE + 4 * i, '0),
                    "readback");
        end
    endtask

    task automatic random_traffic();
        lsu_req_t  reqs[$];
        lsu_rsp_t  exps[$];
        lsu_req_t  r;
        lsu_size_e sz;
        word_t     a;
        int        v;
        for (int i = 0; i < N_RAND; i++) begin
            v  = $random(seed);
            sz = lsu_size_e'(v[1:0] == 2'd3 ? 2'd2 : v[1:0]);
            a  = `LSU_MEM_BASE + {v[11:4], 2'b00};   // Small range for reuse
            a  = a + (sz == SIZE_BYTE ? v[13:12] : sz == SIZE_HALF ? {v[12], 1'b0} : 0);
            if (v[20:17] == 4'd0) a = a + `LSU_MEM_WORDS * 4;
            case (v[31:30])
                2'd0: r = make_req(KIND_PASS, SIZE_WORD, 1'b0, $random(seed), '0);
                2'd1: r = make_req(KIND_STORE, sz, 1'b0, a, $random(seed));
                default: r = make_req(KIND_LOAD, sz, v[14], a, '0);
            endcase
            reqs.push_back(r);
            exps.push_back(model(r));
        end
        fork
            foreach (reqs[i]) send_req(reqs[i]);
            begin
                lsu_rsp_t got;
                repeat (N_RAND) begin
                    get_rsp(got, 1'b1);
                    compare_rsp(got, exps.pop_front(), "ordered response");
                end
            end
        join
        // Nothing may follow the last response
        rsp_ready = 1'b1;
        repeat (4) begin
            if (rsp_valid) begin
                $display("An extra response arrived after the last request was answered");
                $display("** FAIL **");
                $fatal(1, "duplicate response");
            end
            @(posedge clk);
            #1;
        end
        rsp_ready = 1'b0;
    endtask

    initial begin
        rst = 1'b1;
        req_valid = 1'b0;
        req = '0;
        rsp_ready = 1'b0;
        foreach (ref_mem[i]) ref_mem[i] = 8'h00;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);
        #1;
        fill_memory();
        word_store_load();
        sub_word_lanes();
        pass_through();
        fault_access();
        random_traffic();
        $display("** PASS **");
        $finish;
    end

endmodule

/* verilog/axi_if.sv */
interface axi_if;
    import lsu_pkg::*;

    // Write address
    logic       awvalid;
    logic       awready;
    word_t      awaddr;
    logic [3:0] awid;
    logic [7:0] awlen;
    logic [2:0] awsize;
    logic [1:0] awburst;
    // Write data
    logic       wvalid;
    logic       wready;
    word_t      wdata;
    logic [3:0] wstrb;
    logic       wlast;
    // Write response
    logic       bvalid;
    logic       bready;
    logic [1:0] bresp;
    logic [3:0] bid;
    // Read address
    logic       arvalid;
    logic       arready;
    word_t      araddr;
    logic [3:0] arid;
    logic [7:0] arlen;
    logic [2:0] arsize;
    logic [1:0] arburst;
    // Read data
    logic       rvalid;
    logic       rready;
    word_t      rdata;
    logic [1:0] rresp;
    logic       rlast;
    logic [3:0] rid;

    modport master (
        output awvalid, awaddr, awid, awlen, awsize, awburst,
        output wvalid, wdata, wstrb, wlast, bready,
        output arvalid, araddr, arid, arlen, arsize, arburst, rready,
        input  awready, wready, bvalid, bresp, bid,
        input  arready, rvalid, rdata, rresp, rlast, rid
    );

    modport slave (
        input  awvalid, awaddr, awid, awlen, awsize, awburst,
        input  wvalid, wdata, wstrb, wlast, bready,
        input  arvalid, araddr, arid, arlen, arsize, arburst, rready,
        output awready, wready, bvalid, bresp, bid,
        output arready, rvalid, rdata, rresp, rlast, rid
    );

endinterface

/* verilog/axi_mem.sv */
`include "lsu_defines.svh"

module axi_mem (
    input  logic  clk,
    input  logic  rst,
    axi_if.slave  axi
);
    import lsu_pkg::*;

    localparam int unsigned IDX_W   = $clog2(`LSU_MEM_WORDS);
    localparam word_t       MEM_END = `LSU_MEM_BASE + `LSU_MEM_WORDS * 4;

    typedef enum logic [1:0] {
        S_IDLE,
        S_ADDR,
        S_WAIT,
        S_RESP
    } state_e;

    state_e           state;
    logic             is_wr;
    logic [7:0]       wait_cnt;
    word_t            mem [`LSU_MEM_WORDS];
    logic             wr_hs;
    logic             rd_hs;
    logic             wr_ok;
    logic             rd_ok;
    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W-1:0] rd_idx;

    function automatic logic in_window(input word_t a);
        return (a >= `LSU_MEM_BASE) && (a < MEM_END);
    endfunction

    function automatic logic [IDX_W-1:0] word_idx(input word_t a);
        word_t off;
        off = a - `LSU_MEM_BASE;
        return off[IDX_W+1:2];
    endfunction

    assign wr_hs = axi.awvalid && axi.awready && axi.wvalid && axi.wready;
    assign rd_hs = axi.arvalid && axi.arready;

    // Only single beats of at most a word inside the window are served
    assign wr_ok = in_window(axi.awaddr) && (axi.awlen == 8'd0) && axi.wlast
                   && (axi.awburst == `LSU_AXI_BURST_INCR) && (axi.awsize <= 3'd2);
    assign rd_ok = in_window(axi.araddr) && (axi.arlen == 8'd0)
                   && (axi.arburst == `LSU_AXI_BURST_INCR) && (axi.arsize <= 3'd2);
    assign wr_idx = word_idx(axi.awaddr);
    assign rd_idx = word_idx(axi.araddr);
    assign axi.rlast = 1'b1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= S_IDLE;
            is_wr       <= 1'b0;
            wait_cnt    <= 8'd0;
            axi.awready <= 1'b0;
            axi.wready  <= 1'b0;
            axi.arready <= 1'b0;
            axi.bvalid  <= 1'b0;
            axi.rvalid  <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (axi.awvalid && axi.wvalid) begin
                        axi.awready <= 1'b1;
                        axi.wready  <= 1'b1;
                        state       <= S_ADDR;
                    end else if (axi.arvalid) begin
                        axi.arready <= 1'b1;
                        state       <= S_ADDR;
                    end
                end
                S_ADDR: begin   // Handshake happens here
                    axi.awready <= 1'b0;
                    axi.wready  <= 1'b0;
                    axi.arready <= 1'b0;
                    is_wr       <= wr_hs;
                    wait_cnt    <= `LSU_MEM_LAT;
                    state       <= S_WAIT;
                end
                S_WAIT: begin
                    if (wait_cnt <= 8'd1) begin
                        axi.bvalid <= is_wr;
                        axi.rvalid <= !is_wr;
                        state      <= S_RESP;
                    end else begin
                        wait_cnt <= wait_cnt - 8'd1;
                    end
                end
                default: begin
                    if ((axi.bvalid && axi.bready) || (axi.rvalid && axi.rready)) begin
                        axi.bvalid <= 1'b0;
                        axi.rvalid <= 1'b0;
                        state      <= S_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_hs) begin
            if (wr_ok) begin
                for (int i = 0; i < 4; i++) begin
                    if (axi.wstrb[i]) mem[wr_idx][8*i +: 8] <= axi.wdata[8*i +: 8];
                end
            end
            axi.bresp <= wr_ok ? `LSU_AXI_OKAY : `LSU_AXI_SLVERR;
            axi.bid   <= axi.awid;
        end
        if (rd_hs) begin
            axi.rdata <= rd_ok ? mem[rd_idx] : '0;
            axi.rresp <= rd_ok ? `LSU_AXI_OKAY : `LSU_AXI_SLVERR;
            axi.rid   <= axi.arid;
        end
    end

endmodule

/* verilog/lsu_align.sv */
module lsu_align (
    input  lsu_pkg::lsu_size_e size,
    input  logic               sext,
    input  logic [1:0]         addr_lo,
    input  lsu_pkg::word_t     store_data,
    output logic [3:0]         wstrb,
    output lsu_pkg::word_t     wdata_lane,
    input  lsu_pkg::word_t     rdata_raw,
    output lsu_pkg::word_t     load_data
);
    import lsu_pkg::*;

    logic [4:0] shamt;
    word_t      rshift;
    logic       sign_b;
    logic       sign_h;

    assign shamt = {addr_lo, 3'b000};   // Byte offset in bits

    // Store side
    assign wdata_lane = store_data << shamt;

    always_comb begin
        case (size)
            SIZE_BYTE: wstrb = 4'b0001 << addr_lo;
            SIZE_HALF: wstrb = 4'b0011 << addr_lo;
            default:   wstrb = 4'b1111;
        endcase
    end

    // Load side
    assign rshift = rdata_raw >> shamt;
    assign sign_b = sext & rshift[7];
    assign sign_h = sext & rshift[15];

    always_comb begin
        case (size)
            SIZE_BYTE: load_data = {{24{sign_b}}, rshift[7:0]};
            SIZE_HALF: load_data = {{16{sign_h}}, rshift[15:0]};
            default:   load_data = rshift;
        endcase
    end

endmodule

/* verilog/lsu_core.sv */
`include "lsu_defines.svh"

module lsu_core (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    output logic              in_ready,
    input  lsu_pkg::lsu_req_t in_req,
    output logic              out_valid,
    input  logic              out_ready,
    output lsu_pkg::lsu_rsp_t out_rsp,
    axi_if.master             axi
);
    import lsu_pkg::*;

    localparam logic [3:0] AXI_ID = 4'h0;

    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        RESP,
        DONE
    } state_e;

    state_e     state;
    lsu_req_t   req_q;
    word_t      data_q;
    logic       fault_q;
    logic       aw_done;
    logic       w_done;
    logic       r_beat;
    logic       b_beat;
    logic [3:0] strb;
    word_t      wdata_lane;
    word_t      load_data;

    lsu_align u_align (
        .size       (req_q.size),
        .sext       (req_q.sext),
        .addr_lo    (req_q.addr[1:0]),
        .store_data (req_q.wdata),
        .wstrb      (strb),
        .wdata_lane (wdata_lane),
        .rdata_raw  (axi.rdata),
        .load_data  (load_data)
    );

    assign in_ready  = (state == IDLE);
    assign out_valid = (state == DONE);
    assign out_rsp   = '{
        pc:      req_q.pc,
        rd:      req_q.rd,
        gpr_we:  req_q.gpr_we,
        is_load: (req_q.kind == KIND_LOAD),
        data:    data_q,
        fault:   fault_q
    };

    // Single INCR beat, payload straight from the latched request
    assign axi.awaddr  = req_q.addr;
    assign axi.awid    = AXI_ID;
    assign axi.awlen   = 8'd0;
    assign axi.awsize  = {1'b0, req_q.size};
    assign axi.awburst = `LSU_AXI_BURST_INCR;
    assign axi.wdata   = wdata_lane;
    assign axi.wstrb   = strb;
    assign axi.wlast   = 1'b1;
    assign axi.araddr  = req_q.addr;
    assign axi.arid    = AXI_ID;
    assign axi.arlen   = 8'd0;
    assign axi.arsize  = {1'b0, req_q.size};
    assign axi.arburst = `LSU_AXI_BURST_INCR;

    // AW and W may finish in different cycles
    assign aw_done = !axi.awvalid || axi.awready;
    assign w_done  = !axi.wvalid || axi.wready;
    assign r_beat  = axi.rvalid && axi.rready && axi.rlast;
    assign b_beat  = axi.bvalid && axi.bready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= IDLE;
            axi.awvalid <= 1'b0;
            axi.wvalid  <= 1'b0;
            axi.bready  <= 1'b0;
            axi.arvalid <= 1'b0;
            axi.rready  <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (in_valid) begin
                        case (in_req.kind)
                            KIND_LOAD: begin
                                axi.arvalid <= 1'b1;
                                state       <= ADDR;
                            end
                            KIND_STORE: begin
                                axi.awvalid <= 1'b1;
                                axi.wvalid  <= 1'b1;
                                state       <= ADDR;
                            end
                            default: state <= DONE;   // Pass-through
                        endcase
                    end
                end
                ADDR: begin
                    if (req_q.kind == KIND_LOAD) begin
                        if (axi.arready) begin
                            axi.arvalid <= 1'b0;
                            axi.rready  <= 1'b1;
                            state       <= RESP;
                        end
                    end else begin
                        if (axi.awready) axi.awvalid <= 1'b0;
                        if (axi.wready) axi.wvalid <= 1'b0;
                        if (aw_done && w_done) begin
                            axi.bready <= 1'b1;
                            state      <= RESP;
                        end
                    end
                end
                RESP: begin
                    if (r_beat) begin
                        axi.rready <= 1'b0;
                        state      <= DONE;
                    end
                    if (b_beat) begin
                        axi.bready <= 1'b0;
                        state      <= DONE;
                    end
                end
                DONE: begin
                    if (out_ready) state <= IDLE;   // Record taken
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            req_q   <= in_req;
            data_q  <= (in_req.kind == KIND_PASS) ? in_req.addr : '0;
            fault_q <= 1'b0;
        end else begin
            if (r_beat) begin
                data_q  <= load_data;
                fault_q <= (axi.rresp != `LSU_AXI_OKAY) || (axi.rid != AXI_ID);
            end
            if (b_beat) begin
                fault_q <= (axi.bresp != `LSU_AXI_OKAY) || (axi.bid != AXI_ID);
            end
        end
    end

endmodule

/* verilog/lsu_defines.svh */
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// Datapath width, one word
`define LSU_XLEN 32

// SRAM window seen by the stage
`define LSU_MEM_BASE  32'h8000_0000
`define LSU_MEM_WORDS 1024

// Idle cycles between address accept and R/B valid
`define LSU_MEM_LAT 1

// AXI4 encodings
`define LSU_AXI_OKAY       2'b00
`define LSU_AXI_SLVERR     2'b10
`define LSU_AXI_BURST_INCR 2'b01

`endif

/* verilog/lsu_pkg.sv */
`include "lsu_defines.svh"

package lsu_pkg;

    typedef logic [`LSU_XLEN-1:0] word_t;

    typedef enum logic [1:0] {
        KIND_PASS  = 2'd0,
        KIND_LOAD  = 2'd1,
        KIND_STORE = 2'd2
    } lsu_kind_e;

    // Same encoding as AXI size
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } lsu_size_e;

    // Request from execute
    typedef struct packed {
        lsu_kind_e  kind;
        lsu_size_e  size;
        logic       sext;
        logic [4:0] rd;
        logic       gpr_we;
        word_t      pc;
        word_t      addr;   // ALU result for pass-through
        word_t      wdata;
    } lsu_req_t;

    // Writeback record
    typedef struct packed {
        word_t      pc;
        logic [4:0] rd;
        logic       gpr_we;
        logic       is_load;
        word_t      data;
        logic       fault;  // Non-OKAY response
    } lsu_rsp_t;

endpackage

/* verilog/lsu_top.sv */
module lsu_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              req_valid,
    output logic              req_ready,
    input  lsu_pkg::lsu_req_t req,
    output logic              rsp_valid,
    input  logic              rsp_ready,
    output lsu_pkg::lsu_rsp_t rsp
);
    import lsu_pkg::*;

    lsu_req_t core_req;
    logic     core_req_valid;
    logic     core_req_ready;
    lsu_rsp_t core_rsp;
    logic     core_rsp_valid;
    logic     core_rsp_ready;

    axi_if axi_bus ();

    // Execute side
    stage_reg #(
        .T (lsu_pkg::lsu_req_t)
    ) u_req_reg (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (req_valid),
        .in_ready  (req_ready),
        .in_data   (req),
        .out_valid (core_req_valid),
        .out_ready (core_req_ready),
        .out_data  (core_req)
    );

    lsu_core u_core (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (core_req_valid),
        .in_ready  (core_req_ready),
        .in_req    (core_req),
        .out_valid (core_rsp_valid),
        .out_ready (core_rsp_ready),
        .out_rsp   (core_rsp),
        .axi       (axi_bus.master)
    );

    axi_mem u_mem (
        .clk (clk),
        .rst (rst),
        .axi (axi_bus.slave)
    );

    // Writeback side
    stage_reg #(
        .T (lsu_pkg::lsu_rsp_t)
    ) u_rsp_reg (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (core_rsp_valid),
        .in_ready  (core_rsp_ready),
        .in_data   (core_rsp),
        .out_valid (rsp_valid),
        .out_ready (rsp_ready),
        .out_data  (rsp)
    );

endmodule

/* verilog/stage_reg.sv */
module stage_reg #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic rst,
    input  logic in_valid,
    output logic in_ready,
    input  T     in_data,
    output logic out_valid,
    input  logic out_ready,
    output T     out_data
);
    logic full;
    T     data_q;

    // Free, or draining this cycle
    assign in_ready  = !full || out_ready;
    assign out_valid = full;
    assign out_data  = data_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            full <= 1'b0;
        end else if (in_ready) begin
            full <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;
        end
    end

endmodule
